// ==== bu_isa_pkg.sv ====
package bu_isa_pkg;

   localparam int INSN_W   = 32;
   localparam int CLASS_HI = 31;
   localparam int CLASS_LO = 30;
   localparam int CLASS_W  = CLASS_HI - CLASS_LO + 1;

   // instruction class, anything but plain is a branch
   typedef enum logic [CLASS_W-1:0] {
      cls_plain = 2'b00,
      cls_cond  = 2'b01,
      cls_jump  = 2'b10,
      cls_call  = 2'b11
   } insn_class_e;

endpackage

// ==== bu_track_pkg.sv ====
package bu_track_pkg;

   import bu_isa_pkg::*;

   localparam int TAG_W       = 6;
   localparam int POS_W       = 6;
   localparam int GROUP_N     = 4;
   localparam int NUM_ENTRIES = 2;
   localparam int CNT_W       = $clog2(NUM_ENTRIES + 1);

   typedef struct packed {
      logic [GROUP_N-1:0][INSN_W-1:0] insn;   // slot 0 in the low word
      logic [TAG_W-1:0]               next_tag;
      logic [POS_W-1:0]               cur_pos;
      logic [GROUP_N-1:0]             need;
   } dispatch_grp_t;

   // per-slot branch record, also what an entry holds
   typedef struct packed {
      logic             is_branch;
      logic [TAG_W-1:0] tag;
      logic [POS_W-1:0] pos;
   } brch_rec_t;

   typedef struct packed {
      logic             hit;
      logic [TAG_W-1:0] tag;
      logic [POS_W-1:0] pos;
   } flush_t;

   typedef enum logic {
      ent_free = 1'b0,
      ent_busy = 1'b1
   } entry_state_e;

endpackage

// ==== branch_detect.sv ====
module branch_detect
   import bu_isa_pkg::*;
   import bu_track_pkg::*;
(
   input  dispatch_grp_t             grp,
   input  logic                      grp_valid,
   output brch_rec_t [GROUP_N-1:0]   recs
);

   insn_class_e              cls      [GROUP_N];
   logic [GROUP_N-1:0]       is_brch;
   logic [POS_W-1:0]         slot_pos [GROUP_N];
   logic [POS_W-1:0]         pos_run;

   // class field of each word
   always_comb
   begin
      for (int s = 0; s < GROUP_N; s++)
      begin
         cls[s]     = insn_class_e'(grp.insn[s][CLASS_HI:CLASS_LO]);
         is_brch[s] = grp_valid && (cls[s] != cls_plain);
      end
   end

   // position of a slot counts the need bits of the slots below it
   always_comb
   begin
      pos_run = grp.cur_pos;
      for (int s = 0; s < GROUP_N; s++)
      begin
         slot_pos[s] = pos_run;
         pos_run     = pos_run + POS_W'(grp.need[s]);   // wraps at 64
      end
   end

   always_comb
   begin
      for (int s = 0; s < GROUP_N; s++)
      begin
         recs[s].is_branch = is_brch[s];
         recs[s].tag       = grp.next_tag + TAG_W'(s);  // modulo 64
         recs[s].pos       = slot_pos[s];
      end
   end

endmodule

// ==== branch_tracker.sv ====
module branch_tracker
   import bu_track_pkg::*;
(
   input  logic                      clk,
   input  logic                      rst_n,
   input  brch_rec_t [GROUP_N-1:0]   recs,
   input  logic                      cmt_valid,
   input  logic [TAG_W-1:0]          cmt_tag,
   input  logic                      mis_valid,
   input  logic [TAG_W-1:0]          mis_tag,
   output logic                      flush_valid,
   output flush_t                    flush,
   output logic                      all_nop,
   output logic                      overflow,
   output logic [CNT_W-1:0]          busy_cnt
);

   entry_state_e                 state_q [NUM_ENTRIES];
   brch_rec_t                    rec_q   [NUM_ENTRIES];

   logic [NUM_ENTRIES-1:0]       clr;
   logic                         cmt_found;
   logic [NUM_ENTRIES-1:0]       taken;
   brch_rec_t [NUM_ENTRIES-1:0]  alloc_rec;
   logic                         placed;
   logic                         ovf_d;
   flush_t                       flush_d;

   // commit frees the lowest busy entry with a matching tag
   always_comb
   begin
      clr       = '0;
      cmt_found = 1'b0;
      if (cmt_valid && !mis_valid)
      begin
         for (int e = 0; e < NUM_ENTRIES; e++)
         begin
            if (!cmt_found && state_q[e] == ent_busy && rec_q[e].tag == cmt_tag)
            begin
               clr[e]    = 1'b1;
               cmt_found = 1'b1;
            end
         end
      end
   end

   // slots in order take the free entries, lowest first
   // an entry cleared by a commit this cycle is still seen as busy
   always_comb
   begin
      taken     = '0;
      alloc_rec = '0;
      ovf_d     = 1'b0;
      placed    = 1'b0;
      for (int s = 0; s < GROUP_N; s++)
      begin
         if (recs[s].is_branch)
         begin
            placed = 1'b0;
            for (int e = 0; e < NUM_ENTRIES; e++)
            begin
               if (!placed && state_q[e] == ent_free && !taken[e])
               begin
                  taken[e]     = 1'b1;
                  alloc_rec[e] = recs[s];
                  placed       = 1'b1;
               end
            end
            if (!placed)
               ovf_d = 1'b1;   // branch dropped
         end
      end
   end

   // mispredict lookup, walked downward so the lowest entry wins
   always_comb
   begin
      flush_d.hit = 1'b0;
      flush_d.tag = mis_tag;
      flush_d.pos = '0;
      for (int e = NUM_ENTRIES - 1; e >= 0; e--)
      begin
         if (state_q[e] == ent_busy && rec_q[e].tag == mis_tag)
         begin
            flush_d.hit = 1'b1;
            flush_d.tag = rec_q[e].tag;
            flush_d.pos = rec_q[e].pos;
         end
      end
   end

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         for (int e = 0; e < NUM_ENTRIES; e++)
            state_q[e] <= ent_free;
      end
      else if (mis_valid)
      begin
         for (int e = 0; e < NUM_ENTRIES; e++)
            state_q[e] <= ent_free;
      end
      else
      begin
         for (int e = 0; e < NUM_ENTRIES; e++)
         begin
            if (clr[e])
               state_q[e] <= ent_free;
            else if (taken[e])
               state_q[e] <= ent_busy;
         end
      end
   end

   always_ff @(posedge clk)
   begin
      for (int e = 0; e < NUM_ENTRIES; e++)
      begin
         if (taken[e] && !mis_valid)
            rec_q[e] <= alloc_rec[e];
      end
   end

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         flush_valid <= 1'b0;
         flush       <= '0;
         overflow    <= 1'b0;
      end
      else
      begin
         flush_valid <= mis_valid;
         if (mis_valid)
            flush <= flush_d;
         overflow <= ovf_d && !mis_valid;   // group ignored on a mispredict
      end
   end

   always_comb
   begin
      busy_cnt = '0;
      for (int e = 0; e < NUM_ENTRIES; e++)
         busy_cnt = busy_cnt + CNT_W'(state_q[e] == ent_busy);
   end

   assign all_nop = mis_valid;

endmodule

// ==== branch_unit_top.sv ====
module branch_unit_top
   import bu_isa_pkg::*;
   import bu_track_pkg::*;
(
   input  logic                clk,
   input  logic                rst_n,
   input  logic                grp_valid,
   input  logic [INSN_W-1:0]   insn0,
   input  logic [INSN_W-1:0]   insn1,
   input  logic [INSN_W-1:0]   insn2,
   input  logic [INSN_W-1:0]   insn3,
   input  logic [TAG_W-1:0]    next_tag,
   input  logic [POS_W-1:0]    cur_pos,
   input  logic [GROUP_N-1:0]  need,
   input  logic                cmt_valid,
   input  logic [TAG_W-1:0]    cmt_tag,
   input  logic                mis_valid,
   input  logic [TAG_W-1:0]    mis_tag,
   output logic                flush_valid,
   output flush_t              flush,
   output logic                all_nop,
   output logic                overflow,
   output logic [CNT_W-1:0]    busy_cnt
);

   dispatch_grp_t            grp;
   brch_rec_t [GROUP_N-1:0]  recs;

   assign grp.insn     = {insn3, insn2, insn1, insn0};   // slot 0 low
   assign grp.next_tag = next_tag;
   assign grp.cur_pos  = cur_pos;
   assign grp.need     = need;

   branch_detect u_detect (
      .grp       (grp),
      .grp_valid (grp_valid),
      .recs      (recs)
   );

   branch_tracker u_tracker (
      .clk         (clk),
      .rst_n       (rst_n),
      .recs        (recs),
      .cmt_valid   (cmt_valid),
      .cmt_tag     (cmt_tag),
      .mis_valid   (mis_valid),
      .mis_tag     (mis_tag),
      .flush_valid (flush_valid),
      .flush       (flush),
      .all_nop     (all_nop),
      .overflow    (overflow),
      .busy_cnt    (busy_cnt)
   );

endmodule

// ==== tb_branch_unit.sv ====
module tb_branch_unit
   import bu_isa_pkg::*;
   import bu_track_pkg::*;
;

   timeunit 1ns;
   timeprecision 100ps;

   localparam int RESET_CYC    = 3;
   localparam int DIRECTED_CYC = 40;
   localparam int RANDOM_CYC   = 400;
   localparam int TOTAL_CYC    = RESET_CYC + DIRECTED_CYC + RANDOM_CYC;
   localparam int CYC_LIMIT    = TOTAL_CYC * 3 / 2;

   typedef logic [GROUP_N-1:0][CLASS_W-1:0] grp_cls_t;

   // expected tracker contents and registered outputs
   typedef struct packed {
      logic [NUM_ENTRIES-1:0]            busy;
      logic [NUM_ENTRIES-1:0][TAG_W-1:0] tag;
      logic [NUM_ENTRIES-1:0][POS_W-1:0] pos;
      logic                              fv;
      flush_t                            fl;
      logic                              ovf;
   } model_t;

   logic                clk;
   logic                rst_n;
   logic                grp_valid;
   logic [INSN_W-1:0]   insn0, insn1, insn2, insn3;
   logic [TAG_W-1:0]    next_tag;
   logic [POS_W-1:0]    cur_pos;
   logic [GROUP_N-1:0]  need;
   logic                cmt_valid;
   logic [TAG_W-1:0]    cmt_tag;
   logic                mis_valid;
   logic [TAG_W-1:0]    mis_tag;
   logic                flush_valid;
   flush_t              flush;
   logic                all_nop;
   logic                overflow;
   logic [CNT_W-1:0]    busy_cnt;

   logic [31:0]         lfsr = 32'ha0d516e4;
   int                  err_cnt = 0;
   int                  cyc_cnt = 0;
   model_t              m;
   logic                mis_now;

   branch_unit_top DUT (.*);

   initial
   begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   function automatic logic lfsr_bit();
      logic out;
      out  = lfsr[0];
      lfsr = lfsr >> 1;
      if (out)
         lfsr = lfsr ^ 32'h80200003;
      return out;
   endfunction

   function automatic logic [31:0] take_bits(int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++)
         v[i] = lfsr_bit();
      return v;
   endfunction

   function automatic logic [INSN_W-1:0] make_insn(logic [CLASS_W-1:0] cls);
      logic [31:0] body;
      body = take_bits(INSN_W - CLASS_W);
      return {cls, body[INSN_W-CLASS_W-1:0]};
   endfunction

   // one clock of the tracker rules in priority order
   function automatic model_t ref_step(model_t cur, logic gv,
                                       logic [GROUP_N-1:0][INSN_W-1:0] words,
                                       logic [TAG_W-1:0] nt, logic [POS_W-1:0] cp,
                                       logic [GROUP_N-1:0] nd, logic cv,
                                       logic [TAG_W-1:0] ct, logic mv,
                                       logic [TAG_W-1:0] mt);
      model_t                 nxt;
      logic [NUM_ENTRIES-1:0] freed;
      logic [NUM_ENTRIES-1:0] grab;
      logic                   done;
      int                     ones;
      nxt     = cur;
      nxt.fv  = mv;
      nxt.ovf = 1'b0;
      freed   = '0;
      grab    = '0;
      done    = 1'b0;
      ones    = 0;
      if (mv)
      begin
         nxt.fl = '{hit: 1'b0, tag: mt, pos: '0};
         for (int e = 0; e < NUM_ENTRIES; e++)
         begin
            if (!done && cur.busy[e] && cur.tag[e] == mt)
            begin
               nxt.fl = '{hit: 1'b1, tag: cur.tag[e], pos: cur.pos[e]};
               done   = 1'b1;
            end
         end
         nxt.busy = '0;
         return nxt;
      end
      if (cv)
      begin
         for (int e = 0; e < NUM_ENTRIES; e++)
         begin
            if (!done && cur.busy[e] && cur.tag[e] == ct)
            begin
               freed[e] = 1'b1;
               done     = 1'b1;
            end
         end
      end
      for (int s = 0; s < GROUP_N; s++)
      begin
         if (gv && insn_class_e'(words[s][CLASS_HI:CLASS_LO]) != cls_plain)
         begin
            done = 1'b0;
            for (int e = 0; e < NUM_ENTRIES; e++)
            begin
               if (!done && !cur.busy[e] && !grab[e])   // freed entries stay busy
               begin
                  grab[e]    = 1'b1;
                  nxt.tag[e] = nt + TAG_W'(s);
                  nxt.pos[e] = cp + POS_W'(ones);
                  done       = 1'b1;
               end
            end
            if (!done)
               nxt.ovf = 1'b1;
         end
         ones = ones + int'(nd[s]);
      end
      nxt.busy = (cur.busy & ~freed) | grab;
      return nxt;
   endfunction

   task automatic report_fail(string msg);
      err_cnt++;
      $display("Fail at %0d ns: %s", $time, msg);
      $display("Checks failed");
      $fatal(1, "stopped at first error");
   endtask

   // model steps at the rising edge and outputs are compared shortly after
   initial
   begin
      m = '0;
      forever
      begin
         @(posedge clk);
         if (!rst_n)
            m = '0;
         else
            m = ref_step(m, grp_valid, {insn3, insn2, insn1, insn0}, next_tag, cur_pos,
                         need, cmt_valid, cmt_tag, mis_valid, mis_tag);
         mis_now = mis_valid;
         #10;
         assert (busy_cnt == CNT_W'($countones(m.busy)))
            else report_fail($sformatf("busy_cnt %0d, expected %0d", busy_cnt,
                                       $countones(m.busy)));
         assert (flush_valid == m.fv)
            else report_fail($sformatf("flush_valid %0b, expected %0b", flush_valid, m.fv));
         assert (!m.fv || flush.hit == m.fl.hit)
            else report_fail($sformatf("flush.hit %0b, expected %0b", flush.hit, m.fl.hit));
         assert (!(m.fv && m.fl.hit) || (flush.tag == m.fl.tag && flush.pos == m.fl.pos))
            else report_fail($sformatf("flush tag/pos %0d/%0d, expected %0d/%0d",
                                       flush.tag, flush.pos, m.fl.tag, m.fl.pos));
         assert (overflow == m.ovf)
            else report_fail($sformatf("overflow %0b, expected %0b", overflow, m.ovf));
         assert (all_nop == mis_now)
            else report_fail($sformatf("all_nop %0b, expected %0b", all_nop, mis_now));
      end
   end

   initial
   begin
      while (cyc_cnt < CYC_LIMIT)
      begin
         @(posedge clk);
         cyc_cnt++;
      end
      $display("Timeout: the run did not finish within %0d cycles", CYC_LIMIT);
      $display("Checks failed");
      $fatal(1, "timeout");
   end

   task automatic drive(input logic gv, input grp_cls_t cls, input logic [TAG_W-1:0] nt,
                        input logic [POS_W-1:0] cp, input logic [GROUP_N-1:0] nd,
                        input logic cv, input logic [TAG_W-1:0] ct,
                        input logic mv, input logic [TAG_W-1:0] mt);
      @(negedge clk);
      grp_valid = gv;
      insn0     = make_insn(cls[0]);
      insn1     = make_insn(cls[1]);
      insn2     = make_insn(cls[2]);
      insn3     = make_insn(cls[3]);
      next_tag  = nt;
      cur_pos   = cp;
      need      = nd;
      cmt_valid = cv;
      cmt_tag   = ct;
      mis_valid = mv;
      mis_tag   = mt;
   endtask

   task automatic send_group(grp_cls_t cls, logic [TAG_W-1:0] nt, logic [POS_W-1:0] cp,
                             logic [GROUP_N-1:0] nd);
      drive(1'b1, cls, nt, cp, nd, 1'b0, '0, 1'b0, '0);
   endtask

   task automatic send_commit(logic [TAG_W-1:0] t);
      drive(1'b0, '0, '0, '0, '0, 1'b1, t, 1'b0, '0);
   endtask

   task automatic send_mispredict(logic [TAG_W-1:0] t);
      drive(1'b0, '0, '0, '0, '0, 1'b0, '0, 1'b1, t);
   endtask

   task automatic idle_cycles(int n);
      repeat (n)
         drive(1'b0, '0, '0, '0, '0, 1'b0, '0, 1'b0, '0);
   endtask

   initial
   begin
      grp_cls_t cls;
      rst_n     = 1'b0;
      grp_valid = 1'b0;
      insn0     = '0;
      insn1     = '0;
      insn2     = '0;
      insn3     = '0;
      next_tag  = '0;
      cur_pos   = '0;
      need      = '0;
      cmt_valid = 1'b0;
      cmt_tag   = '0;
      mis_valid = 1'b0;
      mis_tag   = '0;
      repeat (RESET_CYC) @(negedge clk);
      rst_n = 1'b1;
      idle_cycles(2);

      // single branches and a position that wraps in the second group
      send_group({cls_plain, cls_cond, cls_plain, cls_plain}, 6'd10, 6'd5, 4'b1011);
      idle_cycles(1);
      send_group({cls_plain, cls_plain, cls_jump, cls_plain}, 6'd62, 6'd63, 4'b0001);
      idle_cycles(1);
      send_mispredict(6'd12);
      idle_cycles(1);
      send_group({cls_plain, cls_plain, cls_plain, cls_plain}, 6'd0, 6'd0, 4'b1111);
      send_group({cls_call, cls_plain, cls_plain, cls_cond}, 6'd20, 6'd30, 4'b0111);
      idle_cycles(1);
      send_mispredict(6'd23);
      idle_cycles(1);

      // more branches than free entries
      send_group({cls_plain, cls_jump, cls_cond, cls_plain}, 6'd40, 6'd2, 4'b0101);
      idle_cycles(1);
      send_group({cls_cond, cls_cond, cls_plain, cls_cond}, 6'd50, 6'd9, 4'b1111);
      idle_cycles(1);
      send_mispredict(6'd50);
      idle_cycles(1);
      send_group({cls_plain, cls_plain, cls_plain, cls_cond}, 6'd8, 6'd1, 4'b0000);
      send_group({cls_jump, cls_plain, cls_jump, cls_jump}, 6'd0, 6'd17, 4'b1001);
      idle_cycles(1);
      send_mispredict(6'd3);
      idle_cycles(1);

      // commits of tracked and untracked tags
      send_group({cls_plain, cls_plain, cls_call, cls_cond}, 6'd16, 6'd44, 4'b0011);
      idle_cycles(1);
      send_commit(6'd17);
      idle_cycles(1);
      send_commit(6'd33);
      idle_cycles(1);
      send_commit(6'd16);
      idle_cycles(1);

      // mispredict wins over a group and a commit in the same cycle
      send_group({cls_plain, cls_plain, cls_cond, cls_cond}, 6'd24, 6'd12, 4'b1100);
      drive(1'b1, {cls_cond, cls_cond, cls_cond, cls_cond}, 6'd30, 6'd0, 4'b1111,
            1'b1, 6'd24, 1'b1, 6'd25);
      idle_cycles(2);

      for (int i = 0; i < RANDOM_CYC; i++)
      begin
         for (int s = 0; s < GROUP_N; s++)
            cls[s] = (take_bits(2) == 0) ? CLASS_W'(take_bits(2)) : cls_plain;
         drive(take_bits(1) == 1, cls, TAG_W'(take_bits(3)), POS_W'(take_bits(6)),
               GROUP_N'(take_bits(4)), take_bits(2) == 0, TAG_W'(take_bits(4)),
               take_bits(3) == 0, TAG_W'(take_bits(4)));
      end
      idle_cycles(3);

      if (err_cnt == 0)
         $display("All checks passed");
      else
         $display("Checks failed");
      $finish;
   end

endmodule

// ==== branch_unit_top.f ====
bu_isa_pkg.sv
bu_track_pkg.sv
branch_detect.sv
branch_tracker.sv
branch_unit_top.sv
tb_branch_unit.sv

// ==== Bender.yml ====
package:
  name: branch_unit

sources:
  - bu_isa_pkg.sv
  - bu_track_pkg.sv
  - branch_detect.sv
  - branch_tracker.sv
  - branch_unit_top.sv
  - target: test
    files:
      - tb_branch_unit.sv

# top levels: branch_unit_top (design), tb_branch_unit (simulation)
